// File: flist.f
wb2axil_pkg.sv
wb2axil_tracker.sv
wb2axil_issue.sv
wb2axil_return.sv
wb2axil_bridge.sv
tb_wb2axil_check.sv
tb_wb2axil.sv

// File: tb_wb2axil.sv
// Testbench top; AXI-Lite slave model answers in order, valid addresses stay in one 256-word window
module tb_wb2axil;

	// Word address window used for normal traffic, top bit selects the error region
	localparam logic [25:0] BASE_WA    = 26'h0123400;
	localparam logic [25:0] ERR_WA     = 26'h2000000;
	localparam int          STEP_LIMIT = 2000;

	// One queued B or R beat of the slave model
	typedef struct packed {
		logic               rd;
		wb2axil_pkg::resp_e resp;
		logic [31:0]        data;
	} beat_t;

	logic                     i_clk = 1'b0;
	logic                     i_reset;
	wb2axil_pkg::wb_req_t     wb_req;
	wb2axil_pkg::wb_rsp_t     wb_rsp;
	logic                     wb_stall;
	wb2axil_pkg::axil_addr_t  aw;
	wb2axil_pkg::axil_wdata_t w;
	wb2axil_pkg::axil_addr_t  ar;
	logic                     awready;
	logic                     wready;
	logic                     arready;
	wb2axil_pkg::axil_b_t     b;
	wb2axil_pkg::axil_r_t     r;
	logic                     bready;
	logic                     rready;
	integer                   seed;
	int                       i;
	int                       stim_errors;
	int                       mismatches;
	int                       failures;
	int                       pending;
	// Slave model state
	logic [31:0]              mem [0:255];
	logic                     mem_set [0:255];
	logic [27:0]              aw_q [$];
	wb2axil_pkg::axil_wdata_t wd_q [$];
	beat_t                    rsp_q [$];
	beat_t                    beat;
	beat_t                    out_beat;
	wb2axil_pkg::axil_wdata_t wbeat;
	logic [27:0]              waddr;
	logic                     presenting;
	logic [31:0]              rdy_bits;
	int                       rsp_delay;
	int                       hold_cycles;
	int                       slave_open;

	always #5 i_clk = ~i_clk;

	wb2axil_bridge i_wb2axil_bridge (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb       (wb_req),
		.o_wb       (wb_rsp),
		.o_wb_stall (wb_stall),
		.o_aw       (aw),
		.i_awready  (awready),
		.o_w        (w),
		.i_wready   (wready),
		.o_ar       (ar),
		.i_arready  (arready),
		.i_b        (b),
		.o_bready   (bready),
		.i_r        (r),
		.o_rready   (rready)
	);

	tb_wb2axil_check check (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wb         (wb_req),
		.i_wb_stall   (wb_stall),
		.i_rsp        (wb_rsp),
		.i_bready     (bready),
		.i_rready     (rready),
		.o_mismatches (mismatches),
		.o_failures   (failures),
		.o_pending    (pending)
	);

	////////////////////////////////////////////////////////////////////////////
	// AXI-Lite slave model
	////////////////////////////////////////////////////////////////////////////

	// Untouched words read back a pattern of their full word address
	function automatic logic [31:0] fill_word(input logic [25:0] wa);
		return {wa, 6'h2d} ^ {6'h15, wa};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] sel);
		logic [31:0] merged;
		int          k;
		merged = old;
		for (k = 0; k < 4; k++)
			if (sel[k])
				merged[8*k +: 8] = data[8*k +: 8];
		return merged;
	endfunction

	function automatic logic [31:0] slave_word(input logic [25:0] wa);
		return mem_set[wa[7:0]] ? mem[wa[7:0]] : fill_word(wa);
	endfunction

	// Decisions at the edge, outputs a little after it
	always @(posedge i_clk)
	begin
		rdy_bits = $random(seed);
		if (i_reset)
		begin
			aw_q.delete();
			wd_q.delete();
			rsp_q.delete();
			presenting = 1'b0;
			rsp_delay  = 0;
			slave_open = 0;
		end
		else
		begin
			// Ready is tied high, so a presented beat has just gone across
			if (presenting)
			begin
				beat = rsp_q.pop_front();
				slave_open--;
				rsp_delay = $random(seed) & 3;
			end
			if (aw.valid && awready)
			begin
				aw_q.push_back(aw.addr);
				slave_open++;
			end
			if (w.valid && wready)
				wd_q.push_back(w);
			// AW and W pair up in arrival order
			while (aw_q.size() > 0 && wd_q.size() > 0)
			begin
				waddr      = aw_q.pop_front();
				wbeat      = wd_q.pop_front();
				beat.rd    = 1'b0;
				beat.data  = 32'h0;
				beat.resp  = waddr[27] ? wb2axil_pkg::RESP_SLVERR : wb2axil_pkg::RESP_OKAY;
				if (!waddr[27])
				begin
					mem[waddr[9:2]]     = merge_bytes(slave_word(waddr[27:2]),
						wbeat.data, wbeat.strb);
					mem_set[waddr[9:2]] = 1'b1;
				end
				rsp_q.push_back(beat);
			end
			if (ar.valid && arready)
			begin
				slave_open++;
				beat.rd   = 1'b1;
				beat.resp = ar.addr[27] ? wb2axil_pkg::RESP_SLVERR : wb2axil_pkg::RESP_OKAY;
				beat.data = ar.addr[27] ? 32'h0 : slave_word(ar.addr[27:2]);
				rsp_q.push_back(beat);
			end
			// Hold lets the bridge fill up to its limit
			if (hold_cycles > 0)
				hold_cycles--;
			presenting = rsp_q.size() > 0 && hold_cycles == 0 && rsp_delay == 0;
			if (rsp_q.size() > 0 && hold_cycles == 0 && rsp_delay > 0)
				rsp_delay--;
		end
		#1;
		awready = rdy_bits[1:0] != 2'b00;
		wready  = rdy_bits[3:2] != 2'b00;
		arready = rdy_bits[5:4] != 2'b00;
		b = '0;
		r = '0;
		if (presenting)
		begin
			out_beat = rsp_q[0];
			if (out_beat.rd)
			begin
				r.valid = 1'b1;
				r.resp  = out_beat.resp;
				r.data  = out_beat.data;
			end
			else
			begin
				b.valid = 1'b1;
				b.resp  = out_beat.resp;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////////////////////////////////////////

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d checker failures, %0d stimulus failures",
			mismatches, failures, stim_errors);
		if (mismatches + failures + stim_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	// One request, offered until the bridge takes it
	task automatic send_request(input logic we, input logic [25:0] wa, input logic [31:0] data,
		input logic [3:0] sel);
		int waited;
		wb_req.cyc  = 1'b1;
		wb_req.stb  = 1'b1;
		wb_req.we   = we;
		wb_req.addr = wa;
		wb_req.data = data;
		wb_req.sel  = sel;
		waited = 0;
		@(posedge i_clk);
		while (wb_stall && waited < STEP_LIMIT)
		begin
			waited++;
			@(posedge i_clk);
		end
		if (wb_stall)
		begin
			stim_errors++;
			$display("timeout: request to word %h was never accepted", wa);
			finish_run();
		end
		#1;
		wb_req.stb = 1'b0;
	endtask

	// Every accepted request answered, or the cycle aborted
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (pending != 0 && waited < STEP_LIMIT)
		begin
			@(posedge i_clk);
			#1;
			waited++;
		end
		if (pending != 0)
		begin
			stim_errors++;
			$display("timeout: %0d requests never got ack or err", pending);
			finish_run();
		end
	endtask

	task automatic end_cycle();
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		@(posedge i_clk);
		#1;
	endtask

	// Error state ends only once the slave has answered every beat
	task automatic wait_unstalled();
		int waited;
		waited = 0;
		@(posedge i_clk);
		while (wb_stall && waited < STEP_LIMIT)
		begin
			waited++;
			@(posedge i_clk);
		end
		#1;
		if (wb_stall)
		begin
			stim_errors++;
			$display("timeout: stall never dropped after the aborted cycle");
			finish_run();
		end
		if (slave_open != 0)
		begin
			stim_errors++;
			$display("stall dropped with %0d AXI responses still owed", slave_open);
		end
	endtask

	task automatic check_reset_state();
		if (wb_stall || wb_rsp.ack || wb_rsp.err || aw.valid || w.valid || ar.valid)
		begin
			stim_errors++;
			$display("after reset the bridge still shows stall, ack, err or an AXI valid");
		end
	endtask

	initial
	begin
		seed        = 70;
		stim_errors = 0;
		hold_cycles = 0;
		i_reset     = 1'b1;
		wb_req      = '0;
		awready     = 1'b0;
		wready      = 1'b0;
		arready     = 1'b0;
		b           = '0;
		r           = '0;
		for (i = 0; i < 256; i++)
			mem_set[i] = 1'b0;
		repeat (5) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		check_reset_state();

		// Writes with mixed byte selects, then the same words read back
		for (i = 0; i < 8; i++)
			send_request(1'b1, BASE_WA + 26'(i), $random(seed), $random(seed));
		for (i = 0; i < 8; i++)
			send_request(1'b0, BASE_WA + 26'(i), 32'h0, 4'hf);
		wait_drained();
		end_cycle();

		// Long stream, direction flips every eight requests
		for (i = 0; i < 64; i++)
			send_request(((i / 8) % 2) == 0, BASE_WA + 26'($random(seed) & 8'hff),
				$random(seed), $random(seed));
		wait_drained();
		end_cycle();

		// Responses held back so the bridge reaches its limit
		hold_cycles = 80;
		for (i = 0; i < 34; i++)
			send_request(1'b1, BASE_WA + 26'(100 + i), $random(seed), 4'hf);
		wait_drained();
		end_cycle();

		// Error response in the middle of a pipelined run
		send_request(1'b1, BASE_WA + 26'(200), 32'h1111_2222, 4'hf);
		send_request(1'b1, BASE_WA + 26'(201), 32'h3333_4444, 4'hf);
		send_request(1'b1, ERR_WA + 26'(3), 32'h5555_6666, 4'hf);
		send_request(1'b1, BASE_WA + 26'(202), 32'h7777_8888, 4'h3);
		wait_drained();
		end_cycle();
		wait_unstalled();
		send_request(1'b0, BASE_WA + 26'(200), 32'h0, 4'hf);
		send_request(1'b0, BASE_WA + 26'(202), 32'h0, 4'hf);
		wait_drained();
		end_cycle();

		// Cycle dropped with writes still in flight
		hold_cycles = 30;
		for (i = 0; i < 5; i++)
			send_request(1'b1, BASE_WA + 26'(40 + i), $random(seed), 4'hf);
		end_cycle();
		wait_unstalled();
		for (i = 0; i < 5; i++)
			send_request(1'b0, BASE_WA + 26'(40 + i), 32'h0, 4'hf);
		wait_drained();
		end_cycle();

		// Quiet tail shows up any late ack or err
		repeat (20) @(posedge i_clk);
		finish_run();
	end

endmodule

// File: tb_wb2axil_check.sv
// Checker for the bridge; the shadow memory assumes the stimulus keeps to one 256-word window
module tb_wb2axil_check (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  wb2axil_pkg::wb_req_t i_wb,
	input  logic                 i_wb_stall,
	input  wb2axil_pkg::wb_rsp_t i_rsp,
	input  logic                 i_bready,
	input  logic                 i_rready,
	output int                   o_mismatches,
	output int                   o_failures,
	output int                   o_pending
);

	localparam int ACK_LIMIT = 1000;

	// What one accepted request should come back as
	typedef struct packed {
		logic        err;
		logic        rd;
		logic [31:0] data;
	} expect_t;

	logic [31:0] shadow [0:255];
	logic        shadow_set [0:255];
	expect_t     exp_q [$];
	expect_t     front;
	int          idle_cycles;
	int          i;

	// Same fill pattern as the slave memory, over the full word address
	function automatic logic [31:0] fill_word(input logic [25:0] wa);
		return {wa, 6'h2d} ^ {6'h15, wa};
	endfunction

	function automatic logic [31:0] shadow_word(input logic [25:0] wa);
		return shadow_set[wa[7:0]] ? shadow[wa[7:0]] : fill_word(wa);
	endfunction

	// Reference: error region by top address bit, read data from the shadow
	function automatic expect_t predict(input wb2axil_pkg::wb_req_t req);
		expect_t e;
		e.err  = req.addr[wb2axil_pkg::WB_ADDR_W-1];
		e.rd   = !req.we;
		e.data = shadow_word(req.addr);
		return e;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] sel);
		logic [31:0] merged;
		int          k;
		merged = old;
		for (k = 0; k < 4; k++)
			if (sel[k])
				merged[8*k +: 8] = data[8*k +: 8];
		return merged;
	endfunction

	initial
	begin
		o_mismatches = 0;
		o_failures   = 0;
		o_pending    = 0;
		idle_cycles  = 0;
		for (i = 0; i < 256; i++)
			shadow_set[i] = 1'b0;
	end

	always @(posedge i_clk)
	begin
		if (i_reset)
		begin
			exp_q.delete();
			idle_cycles = 0;
		end
		else
		begin
			// Response channels are never refused
			if (i_bready !== 1'b1)
			begin
				o_mismatches++;
				$display("mismatch at time %0t: o_bready expected 1 got %b", $time, i_bready);
			end
			if (i_rready !== 1'b1)
			begin
				o_mismatches++;
				$display("mismatch at time %0t: o_rready expected 1 got %b", $time, i_rready);
			end
			// Responses first, they belong to requests from earlier edges
			if (i_rsp.ack || i_rsp.err)
			begin
				idle_cycles = 0;
				if (exp_q.size() == 0)
				begin
					o_failures++;
					$display("at time %0t the bridge gave ack or err with no request pending",
						$time);
				end
				else
				begin
					front = exp_q.pop_front();
					if (i_rsp.err !== front.err)
					begin
						o_mismatches++;
						$display("mismatch at time %0t: o_wb.err expected %0b got %0b",
							$time, front.err, i_rsp.err);
					end
					else if (front.rd && i_rsp.data !== front.data)
					begin
						o_mismatches++;
						$display("mismatch at time %0t: o_wb.data expected %h got %h",
							$time, front.data, i_rsp.data);
					end
					// Err aborts whatever else the cycle had in flight
					if (i_rsp.err)
						exp_q.delete();
				end
			end
			else if (exp_q.size() > 0)
			begin
				idle_cycles++;
				if (idle_cycles == ACK_LIMIT)
				begin
					o_failures++;
					$display("at time %0t no ack or err for %0d cycles", $time, ACK_LIMIT);
				end
			end
			else
				idle_cycles = 0;
			// Master walked away, nothing more is owed
			if (!i_wb.cyc)
				exp_q.delete();
			if (i_wb.cyc && i_wb.stb && !i_wb_stall)
			begin
				if (exp_q.size() > 0 && exp_q[0].rd != !i_wb.we)
				begin
					o_failures++;
					$display("at time %0t a read and a write were both pending", $time);
				end
				exp_q.push_back(predict(i_wb));
				if (i_wb.we && !i_wb.addr[wb2axil_pkg::WB_ADDR_W-1])
				begin
					shadow[i_wb.addr[7:0]]     = merge_bytes(shadow_word(i_wb.addr), i_wb.data,
						i_wb.sel);
					shadow_set[i_wb.addr[7:0]] = 1'b1;
				end
				if (exp_q.size() > int'(wb2axil_pkg::MAX_OUTSTANDING))
				begin
					o_failures++;
					$display("at time %0t more than %0d requests are waiting for ack", $time,
						int'(wb2axil_pkg::MAX_OUTSTANDING));
				end
			end
		end
		o_pending = exp_q.size();
	end

endmodule

// File: wb2axil_bridge.sv
// Pipelined Wishbone master to AXI4-Lite bridge; bready and rready are always high
module wb2axil_bridge (
	input  logic                     i_clk,
	input  logic                     i_reset,
	// Wishbone side
	input  wb2axil_pkg::wb_req_t     i_wb,
	output wb2axil_pkg::wb_rsp_t     o_wb,
	output logic                     o_wb_stall,
	// AXI-Lite request channels
	output wb2axil_pkg::axil_addr_t  o_aw,
	input  logic                     i_awready,
	output wb2axil_pkg::axil_wdata_t o_w,
	input  logic                     i_wready,
	output wb2axil_pkg::axil_addr_t  o_ar,
	input  logic                     i_arready,
	// AXI-Lite response channels
	input  wb2axil_pkg::axil_b_t     i_b,
	output logic                     o_bready,
	input  wb2axil_pkg::axil_r_t     i_r,
	output logic                     o_rready
);

	logic                  accept;
	logic                  backpressure;
	logic                  err_state;
	wb2axil_pkg::rsp_evt_t evt;

	// Responses are never refused
	assign o_bready = 1'b1;
	assign o_rready = 1'b1;

	// Count, direction, error state and stall
	wb2axil_tracker i_wb2axil_tracker (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_wb           (i_wb),
		.i_backpressure (backpressure),
		.i_evt          (evt),
		.o_wb_stall     (o_wb_stall),
		.o_accept       (accept),
		.o_err_state    (err_state)
	);

	// AW, W and AR beats
	wb2axil_issue i_wb2axil_issue (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_accept       (accept),
		.i_wb           (i_wb),
		.i_awready      (i_awready),
		.i_wready       (i_wready),
		.i_arready      (i_arready),
		.o_aw           (o_aw),
		.o_w            (o_w),
		.o_ar           (o_ar),
		.o_backpressure (backpressure)
	);

	// B and R back to ack, err and data
	wb2axil_return i_wb2axil_return (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cyc       (i_wb.cyc),
		.i_err_state (err_state),
		.i_b         (i_b),
		.i_r         (i_r),
		.o_wb        (o_wb),
		.o_evt       (evt)
	);

endmodule

// File: wb2axil_return.sv
// Turns B and R beats into ack or err; assumes only one of B and R is valid per cycle
module wb2axil_return (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_cyc,
	input  logic                  i_err_state,
	input  wb2axil_pkg::axil_b_t  i_b,
	input  wb2axil_pkg::axil_r_t  i_r,
	output wb2axil_pkg::wb_rsp_t  o_wb,
	output wb2axil_pkg::rsp_evt_t o_evt
);

	logic quiet;
	logic ok_beat;

	// Event goes to the tracker in the same cycle as the beat
	assign o_evt.seen = i_b.valid || i_r.valid;
	assign o_evt.err  = (i_b.valid && i_b.resp[1]) || (i_r.valid && i_r.resp[1]);

	// Okay beat on either channel
	assign ok_beat = (i_b.valid && !i_b.resp[1]) || (i_r.valid && !i_r.resp[1]);

	// Master gets nothing after an abort
	assign quiet = !i_cyc || i_err_state;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_wb.ack <= 1'b0;
			o_wb.err <= 1'b0;
		end
		else
		begin
			o_wb.ack <= !quiet && ok_beat;
			o_wb.err <= !quiet && o_evt.err;
		end
		// Read data lines up with the ack of the same beat
		if (i_r.valid)
			o_wb.data <= i_r.data;
	end

	// A B and an R beat in one cycle would answer two requests at once
	a_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_wb.ack && o_wb.err));

endmodule

// File: wb2axil_issue.sv
// Holds the AW, W and AR beats until ready; payload loads only on accept, cache and prot are not driven
module wb2axil_issue (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_accept,
	input  wb2axil_pkg::wb_req_t     i_wb,
	input  logic                     i_awready,
	input  logic                     i_wready,
	input  logic                     i_arready,
	output wb2axil_pkg::axil_addr_t  o_aw,
	output wb2axil_pkg::axil_wdata_t o_w,
	output wb2axil_pkg::axil_addr_t  o_ar,
	output logic                     o_backpressure
);

	logic wr_accept;
	logic rd_accept;

	assign wr_accept = i_accept && i_wb.we;
	assign rd_accept = i_accept && !i_wb.we;

	////////////////////////////////////////////////////////////////////////////
	// Write address channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		// Valid drops on its own ready, a new write may refill it
		if (i_reset)
			o_aw.valid <= 1'b0;
		else
			o_aw.valid <= wr_accept || (o_aw.valid && !i_awready);
		// Word address to byte address
		if (wr_accept)
			o_aw.addr <= {i_wb.addr, 2'b00};
	end

	////////////////////////////////////////////////////////////////////////////
	// Write data channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_w.valid <= 1'b0;
		else
			o_w.valid <= wr_accept || (o_w.valid && !i_wready);
		if (wr_accept)
		begin
			o_w.data <= i_wb.data;
			o_w.strb <= i_wb.sel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read address channel
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ar.valid <= 1'b0;
		else
			o_ar.valid <= rd_accept || (o_ar.valid && !i_arready);
		if (rd_accept)
			o_ar.addr <= {i_wb.addr, 2'b00};
	end

	// Any beat still waiting holds off the next request
	assign o_backpressure = (o_aw.valid && !i_awready)
		|| (o_w.valid && !i_wready)
		|| (o_ar.valid && !i_arready);

	// Direction stall in the tracker keeps reads and writes apart
	a_one_direction: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_ar.valid && (o_aw.valid || o_w.valid)));

endmodule

// File: wb2axil_tracker.sv
// Counts requests in flight and forms the Wishbone stall; assumes responses come back in order
module wb2axil_tracker (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  wb2axil_pkg::wb_req_t  i_wb,
	input  logic                  i_backpressure,
	input  wb2axil_pkg::rsp_evt_t i_evt,
	output logic                  o_wb_stall,
	output logic                  o_accept,
	output logic                  o_err_state
);

	// Requests still owed an ack to the master
	logic [wb2axil_pkg::CNT_W-1:0] ack_cnt;
	logic [wb2axil_pkg::CNT_W-1:0] ack_cnt_d;
	// Requests still owed any AXI response
	logic [wb2axil_pkg::CNT_W-1:0] rsp_cnt;
	logic [wb2axil_pkg::CNT_W-1:0] rsp_cnt_d;
	logic                          full_q;
	logic                          pending;
	logic                          dir_clash;
	wb2axil_pkg::dir_e             dir_q;
	wb2axil_pkg::trk_state_e       state_q;
	wb2axil_pkg::trk_state_e       state_d;

	////////////////////////////////////////////////////////////////////////////
	// Stall and accept
	////////////////////////////////////////////////////////////////////////////

	// BUSY holds exactly while the ack count is non-zero
	assign pending     = (state_q == wb2axil_pkg::TRK_BUSY);
	assign o_err_state = (state_q == wb2axil_pkg::TRK_ERROR);

	// Direction change waits for the bus to empty
	assign dir_clash = pending && (i_wb.we != (dir_q == wb2axil_pkg::DIR_WRITE));

	assign o_wb_stall = i_backpressure || full_q || dir_clash || o_err_state;
	assign o_accept   = i_wb.cyc && i_wb.stb && !o_wb_stall;

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		ack_cnt_d = ack_cnt;
		// Master no longer waits for anything after an abort
		if (o_err_state || !i_wb.cyc || i_evt.err)
			ack_cnt_d = '0;
		else if (o_accept && !i_evt.seen)
			ack_cnt_d = ack_cnt + 1'b1;
		else if (!o_accept && i_evt.seen)
			ack_cnt_d = ack_cnt - 1'b1;
	end

	always_comb
	begin
		rsp_cnt_d = rsp_cnt;
		// Never cleared, the slave still answers every beat it took
		if (o_accept && !i_evt.seen)
			rsp_cnt_d = rsp_cnt + 1'b1;
		else if (!o_accept && i_evt.seen)
			rsp_cnt_d = rsp_cnt - 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			wb2axil_pkg::TRK_ERROR:
			begin
				// Drained once the slave has answered everything
				if (rsp_cnt == '0)
					state_d = wb2axil_pkg::TRK_IDLE;
			end
			default:
			begin
				if (i_evt.err || (pending && !i_wb.cyc))
					state_d = wb2axil_pkg::TRK_ERROR;
				else if (ack_cnt_d != '0)
					state_d = wb2axil_pkg::TRK_BUSY;
				else
					state_d = wb2axil_pkg::TRK_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state_q <= wb2axil_pkg::TRK_IDLE;
			ack_cnt <= '0;
			rsp_cnt <= '0;
			full_q  <= 1'b0;
			dir_q   <= wb2axil_pkg::DIR_READ;
		end
		else
		begin
			state_q <= state_d;
			ack_cnt <= ack_cnt_d;
			rsp_cnt <= rsp_cnt_d;
			// Registered so stall stays a short path
			full_q  <= (ack_cnt_d == wb2axil_pkg::MAX_OUTSTANDING);
			if (o_accept)
				dir_q <= i_wb.we ? wb2axil_pkg::DIR_WRITE : wb2axil_pkg::DIR_READ;
		end
	end

	// Full flag must close the door before the counter overruns
	a_ack_cnt_limit: assert property (@(posedge i_clk) disable iff (i_reset)
		ack_cnt <= wb2axil_pkg::MAX_OUTSTANDING);

endmodule

// File: wb2axil_pkg.sv
// Widths, limits and types of the bridge; 32-bit data only, word addressed, 30 requests at most
package wb2axil_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and limits
	////////////////////////////////////////////////////////////////////////////

	// Data path shared by both buses
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Wishbone side counts words, AXI side counts bytes
	localparam int WB_ADDR_W  = 26;
	localparam int AXI_ADDR_W = WB_ADDR_W + 2;

	// Outstanding request counters
	localparam int CNT_W = 5;
	// Typed so it compares against the counters at full width
	localparam logic [CNT_W-1:0] MAX_OUTSTANDING = CNT_W'(30);

	////////////////////////////////////////////////////////////////////////////
	// Enumerations
	////////////////////////////////////////////////////////////////////////////

	// Direction of the requests in flight
	typedef enum logic {
		DIR_READ  = 1'b0,
		DIR_WRITE = 1'b1
	} dir_e;

	// Tracker state
	typedef enum logic [1:0] {
		TRK_IDLE  = 2'd0,
		TRK_BUSY  = 2'd1,
		TRK_ERROR = 2'd2
	} trk_state_e;

	// AXI response code, upper bit set means an error
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	////////////////////////////////////////////////////////////////////////////
	// Bus bundles
	////////////////////////////////////////////////////////////////////////////

	// Wishbone request from the master
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [WB_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]    data;
		logic [STRB_W-1:0]    sel;
	} wb_req_t;

	// Wishbone response back to the master
	typedef struct packed {
		logic              ack;
		logic              err;
		logic [DATA_W-1:0] data;
	} wb_rsp_t;

	// AW or AR beat
	typedef struct packed {
		logic                  valid;
		logic [AXI_ADDR_W-1:0] addr;
	} axil_addr_t;

	// W beat
	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axil_wdata_t;

	// B beat
	typedef struct packed {
		logic  valid;
		resp_e resp;
	} axil_b_t;

	// R beat
	typedef struct packed {
		logic              valid;
		resp_e             resp;
		logic [DATA_W-1:0] data;
	} axil_r_t;

	// One AXI response seen by the return path
	typedef struct packed {
		logic seen;
		logic err;
	} rsp_evt_t;

endpackage
